// ==== uart_pkg.sv ====
package uart_pkg;

	// ================================================
	// Register map
	// ================================================

	// Offsets compared against paddr[7:0]
	localparam logic [7:0] ADDR_DATA = 8'h00;
	localparam logic [7:0] ADDR_CTRL = 8'h04;

	// Control bits, written at ADDR_CTRL
	localparam int CTRL_PARITY_BIT = 0;
	localparam int CTRL_LOOP_BIT   = 1;

	// Status bits, read back at ADDR_CTRL
	localparam int STAT_RX_EMPTY   = 0;
	localparam int STAT_TX_FULL    = 1;
	localparam int STAT_PARITY_ERR = 2;
	localparam int STAT_OVERRUN    = 3;

	// ================================================
	// Timing and buffering
	// ================================================

	// One bit = CLKS_PER_TICK * TICKS_PER_BIT clocks
	localparam int CLKS_PER_TICK = 4;
	localparam int TICKS_PER_BIT = 16;

	// Depth 16 for both directions
	localparam int FIFO_AW = 4;

	// Serial engine states
	localparam logic [2:0] TX_IDLE   = 3'd0;
	localparam logic [2:0] TX_START  = 3'd1;
	localparam logic [2:0] TX_DATA   = 3'd2;
	localparam logic [2:0] TX_PARITY = 3'd3;
	localparam logic [2:0] TX_STOP   = 3'd4;
	localparam logic [2:0] RX_IDLE   = 3'd0;
	localparam logic [2:0] RX_START  = 3'd1;
	localparam logic [2:0] RX_DATA   = 3'd2;
	localparam logic [2:0] RX_PARITY = 3'd3;
	localparam logic [2:0] RX_STOP   = 3'd4;

endpackage

// ==== uart_baud_gen.sv ====
`timescale 1ns/1ps

module uart_baud_gen (
	input  logic apb_pclk,
	input  logic apb_prstn,
	output logic baud_tick
);

	// Free-running divider, phase fixed by reset
	logic [$clog2(uart_pkg::CLKS_PER_TICK)-1:0] div_cnt;
	logic                                       last_clk;

	// Terminal count of the divider
	assign last_clk = (int'(div_cnt) == uart_pkg::CLKS_PER_TICK - 1);

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			div_cnt   <= '0;
			baud_tick <= 1'b0;
		end
		else
		begin
			// Wrap on terminal count
			if (last_clk)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			// One-cycle pulse, shared by TX and RX
			baud_tick <= last_clk;
		end
	end

endmodule

// ==== uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo #(
	parameter int addr_width = uart_pkg::FIFO_AW
) (
	input  logic       apb_pclk,
	input  logic       apb_prstn,
	input  logic       push,
	input  logic       pop,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       empty,
	output logic       full
);

	// Storage, no reset on payload
	logic [7:0]          mem [0:(1 << addr_width) - 1];
	// Extra MSB tells full from empty
	logic [addr_width:0] wr_ptr;
	logic [addr_width:0] rd_ptr;
	logic                do_push;
	logic                do_pop;

	// Guarded strobes
	assign do_pop  = pop && !empty;
	// push into a full FIFO only lands if a slot frees in the same cycle
	assign do_push = push && (!full || do_pop);

	// Pointer compare
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
		(wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

	// Head entry, visible without a pop
	assign rdata = mem[rd_ptr[addr_width-1:0]];

	always_ff @(posedge apb_pclk)
	begin
		if (do_push)
			mem[wr_ptr[addr_width-1:0]] <= wdata;
	end

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic       apb_pclk,
	input  logic       apb_prstn,
	input  logic       baud_tick,
	input  logic       parity_en,
	input  logic       fifo_empty,
	input  logic [7:0] fifo_data,
	output logic       fifo_pop,
	output logic       txd
);

	logic [2:0]                                 state;
	logic [$clog2(uart_pkg::TICKS_PER_BIT)-1:0] tick_cnt;
	logic [2:0]                                 bit_cnt;
	logic [7:0]                                 shift;
	logic                                       parity;
	logic                                       bit_end;
	logic                                       line_bit;

	// Pull the head byte as soon as the engine is free
	assign fifo_pop = (state == uart_pkg::TX_IDLE) && !fifo_empty;
	// Last tick of the current bit
	assign bit_end = baud_tick && (int'(tick_cnt) == uart_pkg::TICKS_PER_BIT - 1);

	// Line level for the current state
	always_comb
	begin
		case (state)
			uart_pkg::TX_START:  line_bit = 1'b0;
			uart_pkg::TX_DATA:   line_bit = shift[0];
			uart_pkg::TX_PARITY: line_bit = parity;
			default:             line_bit = 1'b1;
		endcase
	end

	// ================================================
	// Frame FSM
	// ================================================
	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			state    <= uart_pkg::TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			parity   <= 1'b0;
			txd      <= 1'b1;
		end
		else
		begin
			// Line only moves on ticks, so every bit is exactly 16 ticks
			if (baud_tick)
				txd <= line_bit;
			if (bit_end)
				tick_cnt <= '0;
			else if (baud_tick && state != uart_pkg::TX_IDLE)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				uart_pkg::TX_IDLE:
					if (fifo_pop)
					begin
						state    <= uart_pkg::TX_START;
						tick_cnt <= '0;
						bit_cnt  <= '0;
						parity   <= 1'b0;
					end
				uart_pkg::TX_START:
					if (bit_end)
						state <= uart_pkg::TX_DATA;
				uart_pkg::TX_DATA:
					if (bit_end)
					begin
						// Even parity over the data bits
						parity  <= parity ^ shift[0];
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= parity_en ? uart_pkg::TX_PARITY : uart_pkg::TX_STOP;
					end
				uart_pkg::TX_PARITY:
					if (bit_end)
						state <= uart_pkg::TX_STOP;
				uart_pkg::TX_STOP:
					if (bit_end)
						state <= uart_pkg::TX_IDLE;
				default:
					state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// Shift register, LSB first
	always_ff @(posedge apb_pclk)
	begin
		if (fifo_pop)
			shift <= fifo_data;
		else if (state == uart_pkg::TX_DATA && bit_end)
			shift <= {1'b0, shift[7:1]};
	end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
	input  logic       apb_pclk,
	input  logic       apb_prstn,
	input  logic       baud_tick,
	input  logic       parity_en,
	input  logic       rxd,
	output logic       rx_done,
	output logic [7:0] rx_byte,
	output logic       rx_perr
);

	logic [1:0]                                 sync;
	logic                                       rx_s;
	logic [2:0]                                 state;
	logic [$clog2(uart_pkg::TICKS_PER_BIT)-1:0] tick_cnt;
	logic [2:0]                                 bit_cnt;
	logic [7:0]                                 shift;
	logic                                       parity;
	logic                                       brk_wait;
	logic                                       mid_start;
	logic                                       mid_bit;

	// Synchronized line
	assign rx_s = sync[1];
	// Half a bit into the start bit
	assign mid_start = baud_tick && (int'(tick_cnt) == uart_pkg::TICKS_PER_BIT / 2 - 1);
	// Middle of every later bit
	assign mid_bit = baud_tick && (int'(tick_cnt) == uart_pkg::TICKS_PER_BIT - 1);

	assign rx_byte = shift;

	// ================================================
	// Frame FSM
	// ================================================
	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			sync     <= 2'b11;
			state    <= uart_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			parity   <= 1'b0;
			brk_wait <= 1'b0;
			rx_done  <= 1'b0;
			rx_perr  <= 1'b0;
		end
		else
		begin
			sync    <= {sync[0], rxd};
			rx_done <= 1'b0;
			// Default count, overridden at sample points
			if (baud_tick)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				uart_pkg::RX_IDLE:
				begin
					tick_cnt <= '0;
					// Line must return high after a bad stop bit
					if (rx_s)
						brk_wait <= 1'b0;
					else if (!brk_wait)
						state <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START:
					if (mid_start)
					begin
						tick_cnt <= '0;
						bit_cnt  <= '0;
						parity   <= 1'b0;
						rx_perr  <= 1'b0;
						// Glitch, not a real start bit
						state <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end
				uart_pkg::RX_DATA:
					if (mid_bit)
					begin
						tick_cnt <= '0;
						parity   <= parity ^ rx_s;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= parity_en ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
					end
				uart_pkg::RX_PARITY:
					if (mid_bit)
					begin
						tick_cnt <= '0;
						// Even parity, mismatch flagged with the byte
						rx_perr  <= rx_s ^ parity;
						state    <= uart_pkg::RX_STOP;
					end
				uart_pkg::RX_STOP:
					if (mid_bit)
					begin
						// Byte delivered even on a framing error
						rx_done  <= 1'b1;
						brk_wait <= !rx_s;
						state    <= uart_pkg::RX_IDLE;
					end
				default:
					state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge apb_pclk)
	begin
		if (state == uart_pkg::RX_DATA && mid_bit)
			shift <= {rx_s, shift[7:1]};
	end

endmodule

// ==== uart_apb_regs.sv ====
`timescale 1ns/1ps

module uart_apb_regs (
	input  logic        apb_pclk,
	input  logic        apb_prstn,
	input  logic        apb_psel,
	input  logic        apb_penable,
	input  logic        apb_pwrite,
	input  logic [31:0] apb_paddr,
	input  logic [31:0] apb_pwdata,
	output logic [31:0] apb_prdata,
	input  logic        tx_full,
	input  logic        rx_empty,
	input  logic        rx_full,
	input  logic [7:0]  rx_head,
	input  logic        rx_done,
	input  logic        rx_perr,
	output logic        tx_push,
	output logic [7:0]  tx_wdata,
	output logic        rx_pop,
	output logic        parity_en,
	output logic        loopback
);

	logic       access;
	logic       sel_data;
	logic       sel_ctrl;
	logic       stat_rd;
	logic       perr_sticky;
	logic       ovr_sticky;
	logic [7:0] status;

	// Access phase and address decode
	assign access   = apb_psel && apb_penable;
	assign sel_data = (apb_paddr[7:0] == uart_pkg::ADDR_DATA);
	assign sel_ctrl = (apb_paddr[7:0] == uart_pkg::ADDR_CTRL);
	assign stat_rd  = access && !apb_pwrite && sel_ctrl;

	// FIFO strobes, dropped when blocked
	assign tx_push  = access && apb_pwrite && sel_data && !tx_full;
	assign tx_wdata = apb_pwdata[7:0];
	assign rx_pop   = access && !apb_pwrite && sel_data && !rx_empty;

	// Status in 3..0, control in 5..4
	always_comb
	begin
		status                            = '0;
		status[uart_pkg::STAT_RX_EMPTY]   = rx_empty;
		status[uart_pkg::STAT_TX_FULL]    = tx_full;
		status[uart_pkg::STAT_PARITY_ERR] = perr_sticky;
		status[uart_pkg::STAT_OVERRUN]    = ovr_sticky;
		status[4 + uart_pkg::CTRL_PARITY_BIT] = parity_en;
		status[4 + uart_pkg::CTRL_LOOP_BIT]   = loopback;
	end

	// Read mux, unmapped reads as zero
	assign apb_prdata = sel_data ? {24'h0, rx_head} :
		sel_ctrl ? {24'h0, status} : 32'h0;

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			parity_en   <= 1'b0;
			loopback    <= 1'b0;
			perr_sticky <= 1'b0;
			ovr_sticky  <= 1'b0;
		end
		else
		begin
			if (access && apb_pwrite && sel_ctrl)
			begin
				parity_en <= apb_pwdata[uart_pkg::CTRL_PARITY_BIT];
				loopback  <= apb_pwdata[uart_pkg::CTRL_LOOP_BIT];
			end
			// New event beats clear-on-read
			if (rx_done && rx_perr)
				perr_sticky <= 1'b1;
			else if (stat_rd)
				perr_sticky <= 1'b0;
			if (rx_done && rx_full)
				ovr_sticky <= 1'b1;
			else if (stat_rd)
				ovr_sticky <= 1'b0;
		end
	end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
	input  logic        apb_pclk,
	input  logic        apb_prstn,
	input  logic        apb_psel,
	input  logic        apb_penable,
	input  logic        apb_pwrite,
	input  logic [31:0] apb_paddr,
	input  logic [31:0] apb_pwdata,
	output logic [31:0] apb_prdata,
	input  logic        rs_rx,
	output logic        rs_tx,
	output logic        uart_irq
);

	logic       baud_tick;
	logic       parity_en;
	logic       loopback;
	// TX path
	logic       tx_push;
	logic [7:0] tx_wdata;
	logic       tx_pop;
	logic [7:0] tx_head;
	logic       tx_empty;
	logic       tx_full;
	// RX path
	logic       rx_pop;
	logic       rx_push;
	logic [7:0] rx_head;
	logic       rx_empty;
	logic       rx_full;
	logic       rx_done;
	logic [7:0] rx_byte;
	logic       rx_perr;
	logic       rx_line;

	// Loopback feeds the TX line into RX, rs_tx keeps driving
	assign rx_line  = loopback ? rs_tx : rs_rx;
	// Byte lost on a full FIFO, regs flag overrun
	assign rx_push  = rx_done && !rx_full;
	assign uart_irq = !rx_empty;

	uart_apb_regs apb_regs_inst (
		.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .apb_psel(apb_psel),
		.apb_penable(apb_penable), .apb_pwrite(apb_pwrite), .apb_paddr(apb_paddr),
		.apb_pwdata(apb_pwdata), .apb_prdata(apb_prdata), .tx_full(tx_full),
		.rx_empty(rx_empty), .rx_full(rx_full), .rx_head(rx_head), .rx_done(rx_done),
		.rx_perr(rx_perr), .tx_push(tx_push), .tx_wdata(tx_wdata), .rx_pop(rx_pop),
		.parity_en(parity_en), .loopback(loopback)
	);

	uart_baud_gen baud_gen_inst (
		.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .baud_tick(baud_tick)
	);

	uart_fifo #(.addr_width(uart_pkg::FIFO_AW)) tx_fifo_inst (
		.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .push(tx_push), .pop(tx_pop),
		.wdata(tx_wdata), .rdata(tx_head), .empty(tx_empty), .full(tx_full)
	);

	uart_fifo #(.addr_width(uart_pkg::FIFO_AW)) rx_fifo_inst (
		.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .push(rx_push), .pop(rx_pop),
		.wdata(rx_byte), .rdata(rx_head), .empty(rx_empty), .full(rx_full)
	);

	uart_tx tx_inst (
		.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .baud_tick(baud_tick),
		.parity_en(parity_en), .fifo_empty(tx_empty), .fifo_data(tx_head),
		.fifo_pop(tx_pop), .txd(rs_tx)
	);

	uart_rx rx_inst (
		.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .baud_tick(baud_tick),
		.parity_en(parity_en), .rxd(rx_line), .rx_done(rx_done),
		.rx_byte(rx_byte), .rx_perr(rx_perr)
	);

endmodule

// ==== uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker (
	input logic       apb_pclk,
	input logic       apb_prstn,
	input logic       uart_irq,
	input logic       rx_push,
	input logic       rx_pop,
	input logic       rx_full,
	input logic       tx_pop,
	input logic       rs_tx,
	input logic [2:0] tx_state
);

	// Count of failed assertions
	int unsigned fail_count = 0;

	// ================================================
	// Interrupt and FIFO protocol
	// ================================================

	// IRQ up the cycle after a byte lands in the RX FIFO
	irq_after_push: assert property (@(posedge apb_pclk) disable iff (!apb_prstn)
		rx_push |=> uart_irq)
	else
	begin
		$error("uart_irq not high after a receive FIFO write");
		fail_count++;
	end

	// Dropped push leaves a full FIFO full
	full_holds: assert property (@(posedge apb_pclk) disable iff (!apb_prstn)
		(rx_full && !rx_pop) |=> rx_full)
	else
	begin
		$error("receive FIFO left the full state without a pop");
		fail_count++;
	end

	// One pop per frame as the engine leaves idle
	pop_one_cycle: assert property (@(posedge apb_pclk) disable iff (!apb_prstn)
		tx_pop |=> (tx_state == uart_pkg::TX_START) && !tx_pop)
	else
	begin
		$error("tx_pop not followed by a single start of frame");
		fail_count++;
	end

	// ================================================
	// Serial line
	// ================================================

	// Idle line is a mark
	tx_idle_high: assert property (@(posedge apb_pclk) disable iff (!apb_prstn)
		(tx_state == uart_pkg::TX_IDLE) |-> rs_tx)
	else
	begin
		$error("rs_tx low while the transmitter was idle");
		fail_count++;
	end

endmodule

bind uart_top uart_checker uart_checker_inst (
	.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .uart_irq(uart_irq),
	.rx_push(rx_push), .rx_pop(rx_pop), .rx_full(rx_full), .tx_pop(tx_pop),
	.rs_tx(rs_tx), .tx_state(tx_inst.state)
);

// ==== tb_uart_top.sv ====
`timescale 1ns/1ps

module tb_uart_top;

	localparam int CLK_NS      = 8;
	localparam int BIT_CLKS    = uart_pkg::CLKS_PER_TICK * uart_pkg::TICKS_PER_BIT;
	localparam int FRAME_CLKS  = 11 * BIT_CLKS;
	// Longest wait for a line edge or a received byte
	localparam int WAIT_CLKS   = 2 * FRAME_CLKS;
	// 60 frames plus slack
	localparam int WATCHDOG_NS = 60 * FRAME_CLKS * CLK_NS + 50000;

	logic        apb_pclk;
	logic        apb_prstn;
	logic        apb_psel;
	logic        apb_penable;
	logic        apb_pwrite;
	logic [31:0] apb_paddr;
	logic [31:0] apb_pwdata;
	logic [31:0] apb_prdata;
	logic        rs_rx;
	logic        rs_tx;
	logic        uart_irq;

	integer      seed = 32'h3e7d47af;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	uart_top uart_top_inst (
		.apb_pclk(apb_pclk), .apb_prstn(apb_prstn), .apb_psel(apb_psel),
		.apb_penable(apb_penable), .apb_pwrite(apb_pwrite), .apb_paddr(apb_paddr),
		.apb_pwdata(apb_pwdata), .apb_prdata(apb_prdata), .rs_rx(rs_rx),
		.rs_tx(rs_tx), .uart_irq(uart_irq)
	);

	initial
	begin
		apb_pclk = 1'b0;
		forever
			#(CLK_NS / 2) apb_pclk = ~apb_pclk;
	end

	// Hang guard
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("Regression failed");
		$finish;
	end

	// ================================================
	// Helpers
	// ================================================

	function automatic logic [7:0] next_byte();
		integer r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Local errors plus bound assertion failures
	function automatic int total_failures();
		return errors + int'(uart_top_inst.uart_checker_inst.fail_count);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error %s: expected 0x%h, got 0x%h", name, exp, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int base);
		tests_run++;
		if (total_failures() == base)
			$display("Test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("Test %0d %s: FAILED", tests_run, name);
		end
	endtask

	// Setup cycle, then access cycle
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge apb_pclk);
		#1;
		apb_psel    = 1'b1;
		apb_penable = 1'b0;
		apb_pwrite  = 1'b1;
		apb_paddr   = {24'h0, addr};
		apb_pwdata  = data;
		@(posedge apb_pclk);
		#1;
		apb_penable = 1'b1;
		@(posedge apb_pclk);
		#1;
		apb_psel    = 1'b0;
		apb_penable = 1'b0;
		apb_pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge apb_pclk);
		#1;
		apb_psel    = 1'b1;
		apb_penable = 1'b0;
		apb_pwrite  = 1'b0;
		apb_paddr   = {24'h0, addr};
		@(posedge apb_pclk);
		#1;
		apb_penable = 1'b1;
		// Read data valid mid access cycle
		@(negedge apb_pclk);
		data = apb_prdata;
		@(posedge apb_pclk);
		#1;
		apb_psel    = 1'b0;
		apb_penable = 1'b0;
	endtask

	task automatic drive_bit(input logic value);
		rs_rx = value;
		repeat (BIT_CLKS) @(posedge apb_pclk);
		#1;
	endtask

	// Start, LSB first data, optional even parity, stop
	task automatic send_frame(input logic [7:0] data, input bit par_on, input bit bad_par);
		int i;
		@(posedge apb_pclk);
		#1;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(data[i]);
		if (par_on)
			drive_bit(^data ^ bad_par);
		drive_bit(1'b1);
	endtask

	task automatic sample_frame(input logic [7:0] exp, input bit par_on);
		logic [7:0] got;
		int         waited;
		int         i;
		waited = 0;
		@(negedge apb_pclk);
		// Start bit edge
		while (rs_tx !== 1'b0 && waited < WAIT_CLKS)
		begin
			@(negedge apb_pclk);
			waited++;
		end
		if (rs_tx !== 1'b0)
		begin
			$display("No start bit appeared on rs_tx in time");
			errors++;
		end
		else
		begin
			repeat (BIT_CLKS / 2) @(negedge apb_pclk);
			check_value("rs_tx start bit", rs_tx, 0);
			for (i = 0; i < 8; i++)
			begin
				repeat (BIT_CLKS) @(negedge apb_pclk);
				got[i] = rs_tx;
			end
			check_value("rs_tx data", got, exp);
			if (par_on)
			begin
				repeat (BIT_CLKS) @(negedge apb_pclk);
				check_value("rs_tx parity bit", rs_tx, ^exp);
			end
			repeat (BIT_CLKS) @(negedge apb_pclk);
			check_value("rs_tx stop bit", rs_tx, 1);
		end
	endtask

	// Writes and line capture run side by side
	task automatic transmit_check(input int count, input bit par_on);
		logic [7:0] sent[$];
		int         i;
		int         j;
		for (i = 0; i < count; i++)
			sent.push_back(next_byte());
		fork
			for (i = 0; i < count; i++)
				apb_write(uart_pkg::ADDR_DATA, {24'h0, sent[i]});
			for (j = 0; j < count; j++)
				sample_frame(sent[j], par_on);
		join
	endtask

	task automatic wait_irq();
		int waited;
		waited = 0;
		@(negedge apb_pclk);
		while (uart_irq !== 1'b1 && waited < WAIT_CLKS)
		begin
			@(negedge apb_pclk);
			waited++;
		end
		if (uart_irq !== 1'b1)
		begin
			$display("Timed out waiting for uart_irq to rise");
			errors++;
		end
	endtask

	// ================================================
	// Test sequence
	// ================================================
	initial
	begin
		logic [31:0] rd;
		logic [7:0]  exp_q[$];
		int          base;
		int          i;
		apb_prstn   = 1'b0;
		apb_psel    = 1'b0;
		apb_penable = 1'b0;
		apb_pwrite  = 1'b0;
		apb_paddr   = 32'h0;
		apb_pwdata  = 32'h0;
		rs_rx       = 1'b1;
		repeat (16) @(posedge apb_pclk);
		#1;
		apb_prstn = 1'b1;

		// Reset values
		base = total_failures();
		@(negedge apb_pclk);
		check_value("rs_tx", rs_tx, 1);
		check_value("uart_irq", uart_irq, 0);
		apb_read(uart_pkg::ADDR_CTRL, rd);
		check_value("apb_prdata status", rd, 32'h1 << uart_pkg::STAT_RX_EMPTY);
		apb_read(8'h08, rd);
		check_value("apb_prdata unmapped", rd, 0);
		finish_test("reset state", base);

		// 8N1 transmit
		base = total_failures();
		transmit_check(4, 1'b0);
		finish_test("transmit 8N1", base);

		// 8E1 transmit
		base = total_failures();
		apb_write(uart_pkg::ADDR_CTRL, 32'h1 << uart_pkg::CTRL_PARITY_BIT);
		transmit_check(3, 1'b1);
		finish_test("transmit 8E1", base);

		// Loopback, read as bytes arrive
		base = total_failures();
		apb_write(uart_pkg::ADDR_CTRL, 32'h1 << uart_pkg::CTRL_LOOP_BIT);
		exp_q.delete();
		for (i = 0; i < 5; i++)
		begin
			exp_q.push_back(next_byte());
			apb_write(uart_pkg::ADDR_DATA, {24'h0, exp_q[i]});
		end
		for (i = 0; i < 5; i++)
		begin
			wait_irq();
			apb_read(uart_pkg::ADDR_DATA, rd);
			check_value("apb_prdata rx data", rd, {24'h0, exp_q[i]});
		end
		@(negedge apb_pclk);
		check_value("uart_irq", uart_irq, 0);
		finish_test("loopback", base);

		// Bad parity on rs_rx, sticky clears on read
		base = total_failures();
		apb_write(uart_pkg::ADDR_CTRL, 32'h1 << uart_pkg::CTRL_PARITY_BIT);
		exp_q.delete();
		exp_q.push_back(next_byte());
		send_frame(exp_q[0], 1'b1, 1'b1);
		wait_irq();
		apb_read(uart_pkg::ADDR_DATA, rd);
		check_value("apb_prdata rx data", rd, {24'h0, exp_q[0]});
		apb_read(uart_pkg::ADDR_CTRL, rd);
		check_value("apb_prdata parity error", rd[uart_pkg::STAT_PARITY_ERR], 1);
		apb_read(uart_pkg::ADDR_CTRL, rd);
		check_value("apb_prdata parity error", rd[uart_pkg::STAT_PARITY_ERR], 0);
		finish_test("parity error", base);

		// 17 frames into a 16-deep FIFO
		base = total_failures();
		apb_write(uart_pkg::ADDR_CTRL, 32'h0);
		exp_q.delete();
		for (i = 0; i < 17; i++)
		begin
			exp_q.push_back(next_byte());
			send_frame(exp_q[i], 1'b0, 1'b0);
		end
		wait_irq();
		apb_read(uart_pkg::ADDR_CTRL, rd);
		check_value("apb_prdata overrun", rd[uart_pkg::STAT_OVERRUN], 1);
		for (i = 0; i < 16; i++)
		begin
			apb_read(uart_pkg::ADDR_DATA, rd);
			check_value("apb_prdata rx data", rd, {24'h0, exp_q[i]});
		end
		@(negedge apb_pclk);
		check_value("uart_irq", uart_irq, 0);
		finish_test("receive overrun", base);

		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, uart_top_inst.uart_checker_inst.fail_count);
		if (total_failures() == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
uart_pkg.sv
uart_baud_gen.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_apb_regs.sv
uart_top.sv
uart_checker.sv
tb_uart_top.sv

// ==== Bender.yml ====
package:
  name: uart_apb

sources:
  - uart_pkg.sv
  - uart_baud_gen.sv
  - uart_fifo.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_apb_regs.sv
  - uart_top.sv
  - target: test
    files:
      - uart_checker.sv
      - tb_uart_top.sv
